// ==== Makefile ====
TOP = pixI2cTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cmdRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmdRegs (
    input wire clk,
    input wire reset,
    input wire [3:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    input wire wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input wire bready,
    input wire [3:0] araddr,
    input wire arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input wire rready,
    output logic cmdStart,
    output logic [6:0] slaveAddr,
    output logic cmdWrite,
    output logic [15:0] regAddr,
    output logic [15:0] writeData,
    output logic [1:0] dataLen,
    input wire cmdDone,
    input wire cmdOk,
    input wire [15:0] readData
);

    logic busy;
    logic done;
    logic ok;
    logic [15:0] statusData;
    logic [1:0] newLen;
    logic cmdBad;
    logic [31:0] cmdWord;
    logic [31:0] statusWord;

    // Length 0 and 3 are not valid transfers
    assign newLen = wdata[pixI2cPkg::CmdLenLsb +: 2];
    assign cmdBad = busy || newLen == 2'd0 || newLen == 2'd3;
    assign rresp = pixI2cPkg::RespOkay;

    // Readback words
    always_comb begin
        cmdWord = '0;
        cmdWord[pixI2cPkg::CmdSlaveLsb +: 7] = slaveAddr;
        cmdWord[pixI2cPkg::CmdWriteBit] = cmdWrite;
        cmdWord[pixI2cPkg::CmdLenLsb +: 2] = dataLen;
        statusWord = '0;
        statusWord[pixI2cPkg::StatusBusyBit] = busy;
        statusWord[pixI2cPkg::StatusDoneBit] = done;
        statusWord[pixI2cPkg::StatusOkBit] = ok;
        statusWord[pixI2cPkg::StatusDataLsb +: 16] = statusData;
    end

    // Write channel and command launch
    always_ff @(posedge clk) begin
        cmdStart <= 1'b0;
        if (reset) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= pixI2cPkg::RespOkay;
            slaveAddr <= '0;
            cmdWrite <= 1'b0;
            dataLen <= '0;
            regAddr <= '0;
            writeData <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            ok <= 1'b0;
            statusData <= '0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready <= awvalid && wvalid && !bvalid && !awready;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (awready && awvalid && wready && wvalid) begin
                bvalid <= 1'b1;
                bresp <= pixI2cPkg::RespOkay;
                case (awaddr)
                    pixI2cPkg::CmdOffset: begin
                        if (cmdBad) begin
                            bresp <= pixI2cPkg::RespSlvErr;
                        end else begin
                            slaveAddr <= wdata[pixI2cPkg::CmdSlaveLsb +: 7];
                            cmdWrite <= wdata[pixI2cPkg::CmdWriteBit];
                            dataLen <= newLen;
                            cmdStart <= 1'b1;
                            busy <= 1'b1;
                            done <= 1'b0;
                        end
                    end
                    pixI2cPkg::RegAddrOffset: regAddr <= wdata[15:0];
                    pixI2cPkg::WrDataOffset: writeData <= wdata[15:0];
                    default: ;
                endcase
            end
            // Result capture, held until the next accepted command
            if (cmdDone) begin
                busy <= 1'b0;
                done <= 1'b1;
                ok <= cmdOk;
                statusData <= readData;
            end
        end
    end

    // Read channel
    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rdata <= '0;
        end else begin
            arready <= !rvalid && !(arready && arvalid);
            if (arready && arvalid) begin
                rvalid <= 1'b1;
                case (araddr)
                    pixI2cPkg::CmdOffset: rdata <= cmdWord;
                    pixI2cPkg::RegAddrOffset: rdata <= {16'h0000, regAddr};
                    pixI2cPkg::WrDataOffset: rdata <= {16'h0000, writeData};
                    pixI2cPkg::StatusOffset: rdata <= statusWord;
                    default: rdata <= '0;
                endcase
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== i2cMaster.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2cMaster #(
    parameter int ClkFreq = 50_000_000,
    parameter int I2cClkFreq = 1_000_000
) (
    input wire clk,
    input wire reset,
    input wire cmdStart,
    input wire [6:0] slaveAddr,
    input wire cmdWrite,
    input wire [15:0] regAddr,
    input wire [15:0] writeData,
    input wire [1:0] dataLen,
    output logic cmdDone,
    output logic cmdOk,
    output logic [15:0] readData,
    output logic i2cClk,
    inout wire i2cData
);

    // Quarter SCL period in ns, rounded up so SCL never runs too fast
    localparam longint QuarterNs = (64'd1_000_000_000 + 4 * I2cClkFreq - 1) / (4 * I2cClkFreq);
    localparam longint QuarterDelay = (QuarterNs * ClkFreq) / 64'd1_000_000_000;
    localparam int DelayWidth = (QuarterDelay > 0) ? $clog2(QuarterDelay + 1) : 1;
    localparam logic [DelayWidth-1:0] Quarter = DelayWidth'(QuarterDelay);

    logic [pixI2cPkg::StateWidth-1:0] state;
    logic [pixI2cPkg::StateWidth-1:0] nextState;
    logic [DelayWidth-1:0] delay;
    logic ack;
    // Output byte with sentinel in bit 0, bit 8 drives SDA
    logic [8:0] dataOutShiftReg;
    // Input bytes shift in above a sentinel
    logic [16:0] dataInShiftReg;
    logic dataIn;

    // Latched command
    logic [6:0] curSlave;
    logic curWrite;
    logic [15:0] curRegAddr;
    logic [15:0] curData;
    logic [1:0] curLen;

    // Open drain pad
    assign i2cData = dataOutShiftReg[8] ? 1'bz : 1'b0;
    assign dataIn = i2cData;
    assign readData = dataInShiftReg[15:0];

    always_ff @(posedge clk) begin
        cmdDone <= 1'b0;
        if (reset) begin
            state <= pixI2cPkg::Idle;
            nextState <= pixI2cPkg::Idle;
            delay <= '0;
            ack <= 1'b0;
            dataOutShiftReg <= '1;
            i2cClk <= 1'b1;
            cmdOk <= 1'b0;
        end else if (delay != '0) begin
            delay <= delay - 1'b1;
        end else begin
            // Most steps last one quarter period
            delay <= Quarter;
            case (state)
                pixI2cPkg::Idle: begin
                    i2cClk <= 1'b1;
                    dataOutShiftReg <= '1;
                    delay <= '0;
                    state <= pixI2cPkg::Start;
                end

                // Wait for a command, then pull SDA low while SCL is high
                pixI2cPkg::Start: begin
                    if (cmdStart) begin
                        curSlave <= slaveAddr;
                        curWrite <= cmdWrite;
                        curRegAddr <= regAddr;
                        curData <= writeData;
                        curLen <= dataLen;
                        dataInShiftReg <= '0;
                        dataOutShiftReg <= '0;
                        state <= pixI2cPkg::Start + 6'd1;
                    end else begin
                        delay <= '0;
                    end
                end
                pixI2cPkg::Start + 6'd1: begin
                    i2cClk <= 1'b0;
                    state <= pixI2cPkg::Start + 6'd2;
                end
                // Address phase always uses the write direction
                pixI2cPkg::Start + 6'd2: begin
                    dataOutShiftReg <= {curSlave, 1'b0, 1'b1};
                    state <= pixI2cPkg::ShiftOut;
                    nextState <= pixI2cPkg::RegAddr;
                end

                // Byte transmit loop, SCL high for two quarters per bit
                pixI2cPkg::ShiftOut: begin
                    i2cClk <= 1'b1;
                    state <= pixI2cPkg::ShiftOut + 6'd1;
                end
                pixI2cPkg::ShiftOut + 6'd1: begin
                    state <= pixI2cPkg::ShiftOut + 6'd2;
                end
                pixI2cPkg::ShiftOut + 6'd2: begin
                    i2cClk <= 1'b0;
                    state <= pixI2cPkg::ShiftOut + 6'd3;
                end
                pixI2cPkg::ShiftOut + 6'd3: begin
                    if (dataOutShiftReg[7:0] != 8'b1000_0000) begin
                        dataOutShiftReg <= {dataOutShiftReg[7:0], 1'b0};
                        state <= pixI2cPkg::ShiftOut;
                    end else begin
                        // Last bit sent, release SDA for the ACK slot
                        dataOutShiftReg <= '1;
                        state <= pixI2cPkg::ShiftOut + 6'd4;
                    end
                end
                pixI2cPkg::ShiftOut + 6'd4: begin
                    i2cClk <= 1'b1;
                    state <= pixI2cPkg::ShiftOut + 6'd5;
                end
                pixI2cPkg::ShiftOut + 6'd5: begin
                    state <= dataIn ? pixI2cPkg::ShiftOut + 6'd7 : pixI2cPkg::ShiftOut + 6'd6;
                end
                pixI2cPkg::ShiftOut + 6'd6: begin
                    i2cClk <= 1'b0;
                    state <= nextState;
                end
                // NACK from the target
                pixI2cPkg::ShiftOut + 6'd7: begin
                    i2cClk <= 1'b0;
                    state <= pixI2cPkg::StopFail;
                end

                // Register address, high byte first
                pixI2cPkg::RegAddr: begin
                    dataOutShiftReg <= {curRegAddr[15:8], 1'b1};
                    state <= pixI2cPkg::ShiftOut;
                    nextState <= pixI2cPkg::RegAddr + 6'd1;
                end
                pixI2cPkg::RegAddr + 6'd1: begin
                    dataOutShiftReg <= {curRegAddr[7:0], 1'b1};
                    state <= pixI2cPkg::ShiftOut;
                    if (!curWrite) begin
                        nextState <= pixI2cPkg::ReadData;
                    end else if (curLen == 2'd2) begin
                        nextState <= pixI2cPkg::WriteData;
                    end else begin
                        nextState <= pixI2cPkg::WriteData + 6'd1;
                    end
                end

                pixI2cPkg::WriteData: begin
                    dataOutShiftReg <= {curData[15:8], 1'b1};
                    state <= pixI2cPkg::ShiftOut;
                    nextState <= pixI2cPkg::WriteData + 6'd1;
                end
                pixI2cPkg::WriteData + 6'd1: begin
                    dataOutShiftReg <= {curData[7:0], 1'b1};
                    state <= pixI2cPkg::ShiftOut;
                    nextState <= pixI2cPkg::StopOk;
                end

                // Repeated start
                pixI2cPkg::ReadData: begin
                    dataOutShiftReg <= '1;
                    state <= pixI2cPkg::ReadData + 6'd1;
                end
                pixI2cPkg::ReadData + 6'd1: begin
                    i2cClk <= 1'b1;
                    state <= pixI2cPkg::ReadData + 6'd2;
                end
                pixI2cPkg::ReadData + 6'd2: begin
                    dataOutShiftReg <= '0;
                    state <= pixI2cPkg::ReadData + 6'd3;
                end
                pixI2cPkg::ReadData + 6'd3: begin
                    i2cClk <= 1'b0;
                    state <= pixI2cPkg::ReadData + 6'd4;
                end
                // Address again, now with the read direction
                pixI2cPkg::ReadData + 6'd4: begin
                    dataOutShiftReg <= {curSlave, 1'b1, 1'b1};
                    dataInShiftReg <= (curLen == 2'd2) ? 17'h0_0001 : 17'h0_0100;
                    state <= pixI2cPkg::ShiftOut;
                    nextState <= pixI2cPkg::ReadData + 6'd5;
                end

                // Byte receive loop
                pixI2cPkg::ReadData + 6'd5: begin
                    dataOutShiftReg <= '1;
                    state <= pixI2cPkg::ReadData + 6'd6;
                end
                pixI2cPkg::ReadData + 6'd6: begin
                    i2cClk <= 1'b1;
                    state <= pixI2cPkg::ReadData + 6'd7;
                end
                pixI2cPkg::ReadData + 6'd7: begin
                    dataInShiftReg <= {dataInShiftReg[15:0], dataIn};
                    state <= pixI2cPkg::ReadData + 6'd8;
                end
                pixI2cPkg::ReadData + 6'd8: begin
                    i2cClk <= 1'b0;
                    if (dataInShiftReg[16:8] == 9'b0_0000_0001) begin
                        // First of two bytes done
                        ack <= 1'b1;
                        state <= pixI2cPkg::Ack;
                        nextState <= pixI2cPkg::ReadData + 6'd5;
                    end else if (dataInShiftReg[16]) begin
                        // Last byte, NACK it
                        ack <= 1'b0;
                        state <= pixI2cPkg::Ack;
                        nextState <= pixI2cPkg::StopOk;
                    end else begin
                        state <= pixI2cPkg::ReadData + 6'd5;
                    end
                end

                // Master ACK or NACK bit
                pixI2cPkg::Ack: begin
                    dataOutShiftReg <= ack ? 9'h000 : 9'h1FF;
                    state <= pixI2cPkg::Ack + 6'd1;
                end
                pixI2cPkg::Ack + 6'd1: begin
                    i2cClk <= 1'b1;
                    state <= pixI2cPkg::Ack + 6'd2;
                end
                pixI2cPkg::Ack + 6'd2: begin
                    state <= pixI2cPkg::Ack + 6'd3;
                end
                pixI2cPkg::Ack + 6'd3: begin
                    i2cClk <= 1'b0;
                    state <= nextState;
                end

                pixI2cPkg::StopOk: begin
                    cmdOk <= 1'b1;
                    dataOutShiftReg <= '0;
                    state <= pixI2cPkg::Stop;
                end
                pixI2cPkg::StopFail: begin
                    cmdOk <= 1'b0;
                    dataOutShiftReg <= '0;
                    state <= pixI2cPkg::Stop;
                end
                // Stop condition, SDA rises while SCL is high
                pixI2cPkg::Stop: begin
                    i2cClk <= 1'b1;
                    state <= pixI2cPkg::Stop + 6'd1;
                end
                pixI2cPkg::Stop + 6'd1: begin
                    dataOutShiftReg <= '1;
                    state <= pixI2cPkg::Stop + 6'd2;
                end
                // Bus free time before the next start
                pixI2cPkg::Stop + 6'd2: begin
                    state <= pixI2cPkg::Stop + 6'd3;
                end
                // Straight back to Start so a new command is never missed
                pixI2cPkg::Stop + 6'd3: begin
                    cmdDone <= 1'b1;
                    delay <= '0;
                    state <= pixI2cPkg::Start;
                end

                default: begin
                    state <= pixI2cPkg::Idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== i2cSensorModel.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2cSensorModel #(
    parameter logic [6:0] DevAddr = 7'h36
) (
    input wire scl,
    inout wire sda
);

    logic [7:0] mem [256];
    logic sdaLow;
    logic active;
    logic reading;
    logic goRead;
    logic masterAck;
    logic [7:0] rxByte;
    logic [7:0] txByte;
    // Only the low register address byte indexes the array
    logic [7:0] ptr;
    int bitCnt;
    int phase;

    assign sda = sdaLow ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5A;
        end
        sdaLow = 1'b0;
        active = 1'b0;
        reading = 1'b0;
        goRead = 1'b0;
        masterAck = 1'b0;
        ptr = '0;
        bitCnt = 0;
        phase = 0;
    end

    task loadByte;
        txByte = mem[ptr];
        ptr = ptr + 8'd1;
        sdaLow = !txByte[7];
    endtask

    // Received byte: address, register high, register low, then data
    task handleByte;
        case (phase)
            0: begin
                if (rxByte[7:1] == DevAddr) begin
                    sdaLow = 1'b1;
                    goRead = rxByte[0];
                end else begin
                    active = 1'b0;
                end
            end
            1: sdaLow = 1'b1;
            2: begin
                ptr = rxByte;
                sdaLow = 1'b1;
            end
            default: begin
                mem[ptr] = rxByte;
                ptr = ptr + 8'd1;
                sdaLow = 1'b1;
            end
        endcase
        if (phase < 3) begin
            phase = phase + 1;
        end
    endtask

    // Start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active = 1'b1;
            reading = 1'b0;
            goRead = 1'b0;
            sdaLow = 1'b0;
            bitCnt = 0;
            phase = 0;
        end
    end

    // Stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active = 1'b0;
            reading = 1'b0;
            sdaLow = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bitCnt < 8) begin
                if (!reading) begin
                    rxByte = {rxByte[6:0], sda === 1'b1};
                end
                bitCnt = bitCnt + 1;
            end else begin
                // ACK slot
                masterAck = (sda === 1'b0);
                bitCnt = 9;
            end
        end
    end

    // SDA only changes while SCL is low
    always @(negedge scl) begin
        if (active) begin
            if (bitCnt == 8) begin
                if (reading) begin
                    sdaLow = 1'b0;
                end else begin
                    handleByte();
                end
            end else if (bitCnt == 9) begin
                bitCnt = 0;
                sdaLow = 1'b0;
                if (goRead) begin
                    goRead = 1'b0;
                    reading = 1'b1;
                    loadByte();
                end else if (reading) begin
                    if (masterAck) begin
                        loadByte();
                    end else begin
                        active = 1'b0;
                    end
                end
            end else if (reading && bitCnt > 0) begin
                sdaLow = !txByte[7 - bitCnt];
            end
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
pixI2cPkg.sv
i2cMaster.sv
cmdRegs.sv
pixI2cCtrl.sv
i2cSensorModel.sv
pixI2cCtrl_chk.sv
pixI2cTb.sv

// ==== pixI2cCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixI2cCtrl #(
    parameter int ClkFreq = 50_000_000,
    parameter int I2cClkFreq = 1_000_000
) (
    input wire clk,
    input wire reset,
    input wire [3:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    input wire wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input wire bready,
    input wire [3:0] araddr,
    input wire arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input wire rready,
    output logic i2cClk,
    inout wire i2cData
);

    // Command from the register front end
    logic cmdStart;
    logic [6:0] slaveAddr;
    logic cmdWrite;
    logic [15:0] regAddr;
    logic [15:0] writeData;
    logic [1:0] dataLen;

    // Result from the engine
    logic cmdDone;
    logic cmdOk;
    logic [15:0] readData;

    cmdRegs cmdRegs_i (
        .clk(clk),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .cmdStart(cmdStart),
        .slaveAddr(slaveAddr),
        .cmdWrite(cmdWrite),
        .regAddr(regAddr),
        .writeData(writeData),
        .dataLen(dataLen),
        .cmdDone(cmdDone),
        .cmdOk(cmdOk),
        .readData(readData)
    );

    i2cMaster #(
        .ClkFreq(ClkFreq),
        .I2cClkFreq(I2cClkFreq)
    ) i2cMaster_i (
        .clk(clk),
        .reset(reset),
        .cmdStart(cmdStart),
        .slaveAddr(slaveAddr),
        .cmdWrite(cmdWrite),
        .regAddr(regAddr),
        .writeData(writeData),
        .dataLen(dataLen),
        .cmdDone(cmdDone),
        .cmdOk(cmdOk),
        .readData(readData),
        .i2cClk(i2cClk),
        .i2cData(i2cData)
    );

endmodule

`default_nettype wire

// ==== pixI2cCtrl_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixI2cCtrl_chk (
    input wire clk,
    input wire reset,
    input wire [1:0] bresp,
    input wire bvalid,
    input wire bready,
    input wire [31:0] rdata,
    input wire rvalid,
    input wire rready,
    input wire cmdStart,
    input wire cmdDone,
    input wire i2cClk,
    input wire i2cData,
    input wire [pixI2cPkg::StateWidth-1:0] engineState
);

    bHeld: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("Write response changed before bready");

    rHeld: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("Read data changed before rready");

    // Done is a single cycle pulse on an idle bus
    donePulse: assert property (@(posedge clk) disable iff (reset)
        cmdDone |-> (i2cClk && i2cData) ##1 !cmdDone)
        else $error("cmdDone before the bus was idle or longer than one cycle");

    startInStart: assert property (@(posedge clk) disable iff (reset)
        cmdStart |-> engineState == pixI2cPkg::Start)
        else $error("cmdStart while the engine is not waiting");

endmodule

bind pixI2cCtrl pixI2cCtrl_chk pixI2cCtrl_chk_i (
    .clk(clk),
    .reset(reset),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .rdata(rdata),
    .rvalid(rvalid),
    .rready(rready),
    .cmdStart(cmdStart),
    .cmdDone(cmdDone),
    .i2cClk(i2cClk),
    .i2cData(i2cData),
    .engineState(i2cMaster_i.state)
);

`default_nettype wire

// ==== pixI2cPkg.sv ====
`default_nettype none

package pixI2cPkg;

    // Register byte offsets
    localparam logic [3:0] CmdOffset = 4'h0;
    localparam logic [3:0] RegAddrOffset = 4'h4;
    localparam logic [3:0] WrDataOffset = 4'h8;
    localparam logic [3:0] StatusOffset = 4'hC;

    // CMD fields
    localparam int CmdSlaveLsb = 0;
    localparam int CmdWriteBit = 8;
    localparam int CmdLenLsb = 16;

    // STATUS fields
    localparam int StatusBusyBit = 0;
    localparam int StatusDoneBit = 1;
    localparam int StatusOkBit = 2;
    localparam int StatusDataLsb = 16;

    localparam logic [1:0] RespOkay = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    // Engine states, each base is followed by its numbered sub-steps
    localparam int StateWidth = 6;
    localparam logic [StateWidth-1:0] Idle = 6'd0;
    localparam logic [StateWidth-1:0] Start = 6'd1;
    localparam logic [StateWidth-1:0] ShiftOut = 6'd4;
    localparam logic [StateWidth-1:0] RegAddr = 6'd12;
    localparam logic [StateWidth-1:0] WriteData = 6'd14;
    localparam logic [StateWidth-1:0] ReadData = 6'd16;
    localparam logic [StateWidth-1:0] Ack = 6'd25;
    localparam logic [StateWidth-1:0] StopOk = 6'd29;
    localparam logic [StateWidth-1:0] StopFail = 6'd30;
    localparam logic [StateWidth-1:0] Stop = 6'd31;

endpackage

`default_nettype wire

// ==== pixI2cTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixI2cTb;

    localparam int NumRows = 9;
    // A two byte read needs roughly 3000 cycles at the default SCL rate
    localparam int CycleLimit = NumRows * 4000;
    localparam logic [6:0] SensorAddr = 7'h36;
    localparam logic [6:0] AbsentAddr = 7'h21;

    logic clk;
    logic reset;
    logic [3:0] awaddr;
    logic awvalid;
    wire awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    wire wready;
    wire [1:0] bresp;
    wire bvalid;
    logic bready;
    logic [3:0] araddr;
    logic arvalid;
    wire arready;
    wire [31:0] rdata;
    wire [1:0] rresp;
    wire rvalid;
    logic rready;
    wire i2cClk;
    wire i2cData;

    // Stimulus table with one array per column
    logic [6:0] rowSlave [NumRows];
    logic rowWrite [NumRows];
    logic [1:0] rowLen [NumRows];
    logic [15:0] rowReg [NumRows];
    logic [15:0] rowData [NumRows];
    logic [1:0] rowExpResp [NumRows];
    logic rowExpOk [NumRows];
    logic [15:0] rowExpData [NumRows];
    logic rowProbeBusy [NumRows];

    int seed;
    int cycleCount = 0;

    // Bus pull-up for the open drain SDA line
    pullup (i2cData);

    pixI2cCtrl pixI2cCtrl_i (
        .clk(clk),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .i2cClk(i2cClk),
        .i2cData(i2cData)
    );

    i2cSensorModel #(
        .DevAddr(SensorAddr)
    ) sensor_i (
        .scl(i2cClk),
        .sda(i2cData)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CycleLimit) begin
            $display("Timeout: the transfers did not finish within %0d cycles", CycleLimit);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERR %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic addRow(input int r, input logic [6:0] slave, input logic isWrite,
                          input logic [1:0] len, input logic [15:0] regA,
                          input logic [15:0] data, input logic [1:0] resp, input logic ok,
                          input logic [15:0] expData, input logic probe);
        rowSlave[r] = slave;
        rowWrite[r] = isWrite;
        rowLen[r] = len;
        rowReg[r] = regA;
        rowData[r] = data;
        rowExpResp[r] = resp;
        rowExpOk[r] = ok;
        rowExpData[r] = expData;
        rowProbeBusy[r] = probe;
    endtask

    // Ready is sampled on the falling edge and the handshake follows on the next rising edge
    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        rready = 1'b1;
        while (!rvalid) @(negedge clk);
        data = rdata;
        checkValue({30'b0, rresp}, {30'b0, pixI2cPkg::RespOkay}, "read response");
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic waitDone(output logic [31:0] status);
        axiRead(pixI2cPkg::StatusOffset, status);
        while (!status[pixI2cPkg::StatusDoneBit]) begin
            axiRead(pixI2cPkg::StatusOffset, status);
        end
    endtask

    initial begin
        logic [1:0] resp;
        logic [31:0] status;
        logic [31:0] cmdWord;
        logic [31:0] randA;
        logic [31:0] randB;
        logic [31:0] randC;
        logic [31:0] randD;
        clk = 1'b0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hF;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        seed = 32'h8d69_0025;
        randA = $random(seed);
        randB = $random(seed);
        randC = $random(seed);
        randD = $random(seed);

        // Read rows expect the bytes of an earlier write with the high byte first
        addRow(0, SensorAddr, 1'b1, 2'd2, 16'h3010, randA[15:0], pixI2cPkg::RespOkay,
               1'b1, 16'h0000, 1'b0);
        addRow(1, SensorAddr, 1'b0, 2'd2, 16'h3010, 16'h0000, pixI2cPkg::RespOkay,
               1'b1, rowData[0], 1'b0);
        addRow(2, SensorAddr, 1'b1, 2'd1, 16'h0120, randB[15:0], pixI2cPkg::RespOkay,
               1'b1, 16'h0000, 1'b0);
        addRow(3, SensorAddr, 1'b0, 2'd1, 16'h0120, 16'h0000, pixI2cPkg::RespOkay,
               1'b1, {8'h00, rowData[2][7:0]}, 1'b0);
        // Nobody answers at this address
        addRow(4, AbsentAddr, 1'b1, 2'd2, 16'h3010, randC[15:0], pixI2cPkg::RespOkay,
               1'b0, 16'h0000, 1'b0);
        addRow(5, SensorAddr, 1'b0, 2'd2, 16'h3010, 16'h0000, pixI2cPkg::RespOkay,
               1'b1, rowData[0], 1'b0);
        addRow(6, SensorAddr, 1'b1, 2'd0, 16'h0040, randC[31:16], pixI2cPkg::RespSlvErr,
               1'b0, 16'h0000, 1'b0);
        addRow(7, SensorAddr, 1'b1, 2'd2, 16'h0200, randD[15:0], pixI2cPkg::RespOkay,
               1'b1, 16'h0000, 1'b1);
        addRow(8, SensorAddr, 1'b0, 2'd2, 16'h0200, 16'h0000, pixI2cPkg::RespOkay,
               1'b1, rowData[7], 1'b0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle state after reset
        axiRead(pixI2cPkg::StatusOffset, status);
        checkValue({31'b0, status[pixI2cPkg::StatusBusyBit]}, 32'd0, "busy after reset");
        checkValue({31'b0, status[pixI2cPkg::StatusDoneBit]}, 32'd0, "done after reset");
        checkValue({31'b0, status[pixI2cPkg::StatusOkBit]}, 32'd0, "ok after reset");
        checkValue({31'b0, i2cData}, 32'd1, "SDA after reset");
        checkValue({31'b0, i2cClk}, 32'd1, "SCL after reset");

        for (int r = 0; r < NumRows; r++) begin
            axiWrite(pixI2cPkg::RegAddrOffset, {16'h0000, rowReg[r]}, resp);
            checkValue({30'b0, resp}, {30'b0, pixI2cPkg::RespOkay},
                       $sformatf("row %0d REGADDR response", r));
            axiWrite(pixI2cPkg::WrDataOffset, {16'h0000, rowData[r]}, resp);
            checkValue({30'b0, resp}, {30'b0, pixI2cPkg::RespOkay},
                       $sformatf("row %0d WRDATA response", r));

            cmdWord = '0;
            cmdWord[pixI2cPkg::CmdSlaveLsb +: 7] = rowSlave[r];
            cmdWord[pixI2cPkg::CmdWriteBit] = rowWrite[r];
            cmdWord[pixI2cPkg::CmdLenLsb +: 2] = rowLen[r];
            axiWrite(pixI2cPkg::CmdOffset, cmdWord, resp);
            checkValue({30'b0, resp}, {30'b0, rowExpResp[r]},
                       $sformatf("row %0d CMD response", r));

            if (rowProbeBusy[r]) begin
                axiWrite(pixI2cPkg::CmdOffset, cmdWord, resp);
                checkValue({30'b0, resp}, {30'b0, pixI2cPkg::RespSlvErr},
                           $sformatf("row %0d CMD response while busy", r));
            end

            if (rowExpResp[r] == pixI2cPkg::RespOkay) begin
                waitDone(status);
                checkValue({31'b0, status[pixI2cPkg::StatusBusyBit]}, 32'd0,
                           $sformatf("row %0d busy at done", r));
                checkValue({31'b0, status[pixI2cPkg::StatusOkBit]}, {31'b0, rowExpOk[r]},
                           $sformatf("row %0d ok flag", r));
                if (!rowWrite[r]) begin
                    checkValue({16'h0000, status[pixI2cPkg::StatusDataLsb +: 16]},
                               {16'h0000, rowExpData[r]},
                               $sformatf("row %0d read data", r));
                end
            end else begin
                // Rejected command must not start the engine
                axiRead(pixI2cPkg::StatusOffset, status);
                checkValue({31'b0, status[pixI2cPkg::StatusBusyBit]}, 32'd0,
                           $sformatf("row %0d busy after rejected CMD", r));
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
